// File: design/rob_cfg_pkg.sv
// ========================================================================
// Reorder buffer sizing defaults
// Log2 values for the bank count, the per-bank depth and the number of
// writeback ports. The top level takes these as parameter defaults.
// ========================================================================

`default_nettype none

package rob_cfg_pkg;

   // Four banks, which also sets the issue and commit width
   localparam int P_BANKS_DEF = 2;

   // Eight entries per bank
   localparam int P_DEPTH_DEF = 3;

   // Two writeback ports
   localparam int P_WB_DEF    = 1;

endpackage

`default_nettype wire

// File: design/rob_entry_pkg.sv
// ========================================================================
// Reorder buffer entry fields
// Types of the fields carried by one entry and the packed payload width.
// ========================================================================

`default_nettype none

package rob_entry_pkg;

   typedef logic [31:0] pc_t;
   typedef logic [4:0]  lreg_t;
   typedef logic [5:0]  preg_t;
   typedef logic [31:0] data_t;

   // Packed as pc, lrd, prd, prd_we from msb down
   localparam int PAYLOAD_W = $bits(pc_t) + $bits(lreg_t) + $bits(preg_t) + 1;

endpackage

`default_nettype wire

// File: design/rob_bank.sv
// ========================================================================
// Reorder buffer bank
// Circular queue of entry payloads with done and exception tags and a
// result array. Head entry is read combinationally.
// ========================================================================

`default_nettype none

module rob_bank #(
   parameter int P_DEPTH = rob_cfg_pkg::P_DEPTH_DEF
)
(
   input  wire logic                                 clk,
   input  wire logic                                 arst_n,
   input  wire logic                                 flush,
   input  wire logic                                 push,
   input  wire logic [rob_entry_pkg::PAYLOAD_W-1:0]  push_payload,
   input  wire logic                                 pop,
   input  wire logic                                 wb_we,
   input  wire logic [P_DEPTH-1:0]                   wb_id,
   input  wire logic                                 wb_exc,
   input  wire rob_entry_pkg::data_t                 wb_data,
   output logic                                      not_full,
   output logic [P_DEPTH-1:0]                        wptr,
   output logic                                      head_valid,
   output logic [rob_entry_pkg::PAYLOAD_W-1:0]       head_payload,
   output logic                                      head_done,
   output logic                                      head_exc,
   output rob_entry_pkg::data_t                      head_data
);

   localparam int DEPTH = 1 << P_DEPTH;

   // Pointers carry a wrap bit above the index
   logic [P_DEPTH:0]                     rd_ptr;
   logic [P_DEPTH:0]                     wr_ptr;
   logic [rob_entry_pkg::PAYLOAD_W-1:0]  payload_mem [DEPTH];
   rob_entry_pkg::data_t                 data_mem [DEPTH];
   logic [DEPTH-1:0]                     done_tag;
   logic [DEPTH-1:0]                     exc_tag;
   logic                                 push_en;
   logic                                 pop_en;
   logic [P_DEPTH-1:0]                   rd_idx;
   logic [P_DEPTH-1:0]                   wr_idx;

   assign rd_idx = rd_ptr[P_DEPTH-1:0];
   assign wr_idx = wr_ptr[P_DEPTH-1:0];

   // Full when indices match but wrap bits differ
   assign not_full   = ~((rd_ptr[P_DEPTH] != wr_ptr[P_DEPTH]) && (rd_idx == wr_idx));
   assign head_valid = (rd_ptr != wr_ptr);
   assign push_en    = push & not_full;
   assign pop_en     = pop & head_valid;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
      end
      else if (flush)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
      end
      else
      begin
         if (push_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_en)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // Tags cleared on push, set by writeback
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         done_tag <= '0;
         exc_tag  <= '0;
      end
      else if (flush)
      begin
         done_tag <= '0;
         exc_tag  <= '0;
      end
      else
      begin
         if (push_en)
         begin
            done_tag[wr_idx] <= 1'b0;
            exc_tag[wr_idx]  <= 1'b0;
         end
         if (wb_we)
         begin
            done_tag[wb_id] <= 1'b1;
            exc_tag[wb_id]  <= wb_exc;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (push_en)
         payload_mem[wr_idx] <= push_payload;
      if (wb_we)
         data_mem[wb_id] <= wb_data;
   end

   assign wptr         = wr_idx;
   assign head_payload = payload_mem[rd_idx];
   assign head_done    = done_tag[rd_idx];
   assign head_exc     = exc_tag[rd_idx];
   assign head_data    = data_mem[rd_idx];

endmodule

`default_nettype wire

// File: design/rob_wb_router.sv
// ========================================================================
// Writeback router
// Resolves bank conflicts between writeback ports and steers each
// accepted write to the strobe and fields of its bank.
// ========================================================================

`default_nettype none

module rob_wb_router #(
   parameter int P_BANKS = rob_cfg_pkg::P_BANKS_DEF,
   parameter int P_DEPTH = rob_cfg_pkg::P_DEPTH_DEF,
   parameter int P_WB    = rob_cfg_pkg::P_WB_DEF
)
(
   input  wire logic [(1<<P_WB)-1:0]                    wb_valid,
   input  wire logic [(1<<P_WB)-1:0][P_DEPTH-1:0]       wb_rob_id,
   input  wire logic [(1<<P_WB)-1:0][P_BANKS-1:0]       wb_rob_bank,
   input  wire logic [(1<<P_WB)-1:0]                    wb_exc,
   input  wire rob_entry_pkg::data_t [(1<<P_WB)-1:0]    wb_data,
   output logic [(1<<P_WB)-1:0]                         wb_rob_ready,
   output logic [(1<<P_BANKS)-1:0]                      bank_we,
   output logic [(1<<P_BANKS)-1:0][P_DEPTH-1:0]         bank_wid,
   output logic [(1<<P_BANKS)-1:0]                      bank_wexc,
   output rob_entry_pkg::data_t [(1<<P_BANKS)-1:0]      bank_wdata
);

   localparam int WW    = 1 << P_WB;
   localparam int BANKS = 1 << P_BANKS;

   logic [WW-1:0] wb_fire;

   // Port 0 never stalls; a later port yields to any earlier valid port
   // aimed at the same bank
   always_comb
   begin
      wb_rob_ready = '1;
      for (int j = 1; j < WW; j++)
         for (int k = 0; k < j; k++)
            if (wb_valid[k] && (wb_rob_bank[k] == wb_rob_bank[j]))
               wb_rob_ready[j] = 1'b0;
   end

   assign wb_fire = wb_valid & wb_rob_ready;

   // At most one fired port per bank, so OR merge is safe
   always_comb
   begin
      bank_we    = '0;
      bank_wid   = '0;
      bank_wexc  = '0;
      bank_wdata = '0;
      for (int b = 0; b < BANKS; b++)
         for (int j = 0; j < WW; j++)
            if (wb_fire[j] && (wb_rob_bank[j] == P_BANKS'(b)))
            begin
               bank_we[b]    = 1'b1;
               bank_wid[b]   = bank_wid[b] | wb_rob_id[j];
               bank_wexc[b]  = bank_wexc[b] | wb_exc[j];
               bank_wdata[b] = bank_wdata[b] | wb_data[j];
            end
   end

endmodule

`default_nettype wire

// File: design/rob_top.sv
// ========================================================================
// Banked reorder buffer
// Head and tail bank pointers, push lane rotation, free slot report and
// the in-order commit view over the per-bank queues.
// ========================================================================

`default_nettype none

module rob_top #(
   parameter int P_BANKS = rob_cfg_pkg::P_BANKS_DEF,
   parameter int P_DEPTH = rob_cfg_pkg::P_DEPTH_DEF,
   parameter int P_WB    = rob_cfg_pkg::P_WB_DEF
)
(
   input  wire logic                                      clk,
   input  wire logic                                      arst_n,
   input  wire logic                                      flush,
   // Issue side
   input  wire logic [P_BANKS:0]                          rob_push_size,
   input  wire rob_entry_pkg::pc_t   [(1<<P_BANKS)-1:0]   rob_push_pc,
   input  wire rob_entry_pkg::lreg_t [(1<<P_BANKS)-1:0]   rob_push_lrd,
   input  wire rob_entry_pkg::preg_t [(1<<P_BANKS)-1:0]   rob_push_prd,
   input  wire logic [(1<<P_BANKS)-1:0]                   rob_push_prd_we,
   output logic                                           rob_ready,
   output logic [(1<<P_BANKS)-1:0][P_DEPTH-1:0]           rob_free_id,
   output logic [(1<<P_BANKS)-1:0][P_BANKS-1:0]           rob_free_bank,
   // Writeback side
   input  wire logic [(1<<P_WB)-1:0]                      wb_valid,
   input  wire logic [(1<<P_WB)-1:0][P_DEPTH-1:0]         wb_rob_id,
   input  wire logic [(1<<P_WB)-1:0][P_BANKS-1:0]         wb_rob_bank,
   input  wire logic [(1<<P_WB)-1:0]                      wb_exc,
   input  wire rob_entry_pkg::data_t [(1<<P_WB)-1:0]      wb_data,
   output logic [(1<<P_WB)-1:0]                           wb_rob_ready,
   // Commit side
   output logic [(1<<P_BANKS)-1:0]                        cmt_valid,
   output rob_entry_pkg::pc_t   [(1<<P_BANKS)-1:0]        cmt_pc,
   output rob_entry_pkg::lreg_t [(1<<P_BANKS)-1:0]        cmt_lrd,
   output rob_entry_pkg::preg_t [(1<<P_BANKS)-1:0]        cmt_prd,
   output logic [(1<<P_BANKS)-1:0]                        cmt_prd_we,
   output logic [(1<<P_BANKS)-1:0]                        cmt_exc,
   output rob_entry_pkg::data_t [(1<<P_BANKS)-1:0]        cmt_data,
   input  wire logic [P_BANKS:0]                          cmt_pop_size
);

   localparam int BANKS = 1 << P_BANKS;
   localparam int PW    = rob_entry_pkg::PAYLOAD_W;

   logic [P_BANKS-1:0]                   head;
   logic [P_BANKS-1:0]                   tail;
   logic [PW-1:0]                        lane_payload [BANKS];
   logic [PW-1:0]                        bank_din [BANKS];
   logic [BANKS-1:0]                     bank_push;
   logic [BANKS-1:0]                     bank_pop;
   logic [BANKS-1:0]                     bank_not_full;
   logic [P_DEPTH-1:0]                   bank_wptr [BANKS];
   logic [BANKS-1:0]                     bank_hvalid;
   logic [PW-1:0]                        bank_hpayload [BANKS];
   logic [BANKS-1:0]                     bank_hdone;
   logic [BANKS-1:0]                     bank_hexc;
   rob_entry_pkg::data_t                 bank_hdata [BANKS];
   logic [BANKS-1:0]                     wr_we;
   logic [BANKS-1:0][P_DEPTH-1:0]        wr_id;
   logic [BANKS-1:0]                     wr_exc;
   rob_entry_pkg::data_t [BANKS-1:0]     wr_data;
   logic [BANKS-1:0]                     ent_valid;

   // Size fields wrap modulo the bank count
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         head <= '0;
         tail <= '0;
      end
      else if (flush)
      begin
         head <= '0;
         tail <= '0;
      end
      else
      begin
         head <= head + cmt_pop_size[P_BANKS-1:0];
         tail <= tail + rob_push_size[P_BANKS-1:0];
      end
   end

   rob_wb_router #(
      .P_BANKS (P_BANKS),
      .P_DEPTH (P_DEPTH),
      .P_WB    (P_WB)
   ) u_wb_router (
      .wb_valid     (wb_valid),
      .wb_rob_id    (wb_rob_id),
      .wb_rob_bank  (wb_rob_bank),
      .wb_exc       (wb_exc),
      .wb_data      (wb_data),
      .wb_rob_ready (wb_rob_ready),
      .bank_we      (wr_we),
      .bank_wid     (wr_id),
      .bank_wexc    (wr_exc),
      .bank_wdata   (wr_data)
   );

   for (genvar b = 0; b < BANKS; b++)
   begin : g_bank
      logic [P_BANKS-1:0] push_off;
      logic [P_BANKS-1:0] pop_off;

      // Distance of this bank from the tail and head pointers
      assign push_off     = P_BANKS'(b) - tail;
      assign pop_off      = P_BANKS'(b) - head;
      assign bank_push[b] = ({1'b0, push_off} < rob_push_size);
      assign bank_pop[b]  = ({1'b0, pop_off} < cmt_pop_size);
      assign bank_din[b]  = lane_payload[push_off];

      rob_bank #(
         .P_DEPTH (P_DEPTH)
      ) u_bank (
         .clk          (clk),
         .arst_n       (arst_n),
         .flush        (flush),
         .push         (bank_push[b]),
         .push_payload (bank_din[b]),
         .pop          (bank_pop[b]),
         .wb_we        (wr_we[b]),
         .wb_id        (wr_id[b]),
         .wb_exc       (wr_exc[b]),
         .wb_data      (wr_data[b]),
         .not_full     (bank_not_full[b]),
         .wptr         (bank_wptr[b]),
         .head_valid   (bank_hvalid[b]),
         .head_payload (bank_hpayload[b]),
         .head_done    (bank_hdone[b]),
         .head_exc     (bank_hexc[b]),
         .head_data    (bank_hdata[b])
      );
   end

   for (genvar i = 0; i < BANKS; i++)
   begin : g_lane
      logic [P_BANKS-1:0] cmt_bank;

      assign lane_payload[i] = {rob_push_pc[i], rob_push_lrd[i],
                                rob_push_prd[i], rob_push_prd_we[i]};

      // Slot this lane would take if pushed now
      assign rob_free_bank[i] = tail + P_BANKS'(i);
      assign rob_free_id[i]   = bank_wptr[rob_free_bank[i]];

      // Commit lane i looks at bank head + i
      assign cmt_bank     = head + P_BANKS'(i);
      assign {cmt_pc[i], cmt_lrd[i], cmt_prd[i], cmt_prd_we[i]} = bank_hpayload[cmt_bank];
      assign cmt_exc[i]   = bank_hexc[cmt_bank];
      assign cmt_data[i]  = bank_hdata[cmt_bank];
      assign ent_valid[i] = bank_hvalid[cmt_bank] & bank_hdone[cmt_bank];
   end

   // Lane stays valid only while all older lanes are done
   always_comb
   begin
      cmt_valid[0] = ent_valid[0];
      for (int i = 1; i < BANKS; i++)
         cmt_valid[i] = cmt_valid[i-1] & ent_valid[i];
   end

   assign rob_ready = &bank_not_full;

endmodule

`default_nettype wire

// File: bench/rob_props.sv
// ============================================================================
// Reorder buffer properties
// Commit prefix, port 0 readiness and flush clearing, bound to rob_top.
// ============================================================================

`default_nettype none

module rob_props #(
   parameter int P_BANKS = rob_cfg_pkg::P_BANKS_DEF,
   parameter int P_WB    = rob_cfg_pkg::P_WB_DEF
)
(
   input wire logic                     clk,
   input wire logic                     arst_n,
   input wire logic                     flush,
   input wire logic [(1<<P_BANKS)-1:0]  cmt_valid,
   input wire logic [(1<<P_WB)-1:0]     wb_rob_ready
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NB = 1 << P_BANKS;

   // A prefix plus one has no bits in common with itself
   a_prefix: assert property (@(posedge clk) disable iff (!arst_n)
      (cmt_valid & (cmt_valid + NB'(1))) == '0)
      else $error("cmt_valid is not a contiguous prefix");

   a_port0: assert property (@(posedge clk) disable iff (!arst_n) wb_rob_ready[0])
      else $error("writeback port 0 not ready");

   a_flush: assert property (@(posedge clk) disable iff (!arst_n) flush |=> cmt_valid == '0)
      else $error("cmt_valid not clear after flush");

endmodule

`default_nettype wire

// File: bench/tb_rob.sv
// ============================================================================
// Reorder buffer testbench
// Runs commands from the pattern file against rob_top and checks push,
// writeback and commit results against a queue model of the buffer.
// ============================================================================

`default_nettype none

module tb_rob;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int P_BANKS = rob_cfg_pkg::P_BANKS_DEF;
   localparam int P_DEPTH = rob_cfg_pkg::P_DEPTH_DEF;
   localparam int P_WB    = rob_cfg_pkg::P_WB_DEF;
   localparam int NB      = 1 << P_BANKS;
   localparam int ND      = 1 << P_DEPTH;
   localparam int NW      = 1 << P_WB;

   logic                              clk;
   logic                              arst_n;
   logic                              flush;
   logic [P_BANKS:0]                  push_size;
   logic [NB-1:0][31:0]               push_pc;
   logic [NB-1:0][4:0]                push_lrd;
   logic [NB-1:0][5:0]                push_prd;
   logic [NB-1:0]                     push_we;
   logic                              rob_ready;
   logic [NB-1:0][P_DEPTH-1:0]        free_id;
   logic [NB-1:0][P_BANKS-1:0]        free_bank;
   logic [NW-1:0]                     wb_valid;
   logic [NW-1:0][P_DEPTH-1:0]        wb_id;
   logic [NW-1:0][P_BANKS-1:0]        wb_bank;
   logic [NW-1:0]                     wb_exc;
   logic [NW-1:0][31:0]               wb_data;
   logic [NW-1:0]                     wb_ready;
   logic [NB-1:0]                     cmt_valid;
   logic [NB-1:0][31:0]               cmt_pc;
   logic [NB-1:0][4:0]                cmt_lrd;
   logic [NB-1:0][5:0]                cmt_prd;
   logic [NB-1:0]                     cmt_we;
   logic [NB-1:0]                     cmt_exc;
   logic [NB-1:0][31:0]               cmt_data;
   logic [P_BANKS:0]                  pop_size;

   // Model of the buffer contents, oldest first
   logic [31:0] q_pc[$];
   logic [4:0]  q_lrd[$];
   logic [5:0]  q_prd[$];
   bit          q_we[$];
   bit          q_done[$];
   int          q_bank[$];
   int          q_id[$];
   int          push_cnt[NB];
   int          pop_cnt[NB];
   int          tail_cnt;
   int          errors;
   int          cycles;
   int          limit;

   rob_top #(.P_BANKS(P_BANKS), .P_DEPTH(P_DEPTH), .P_WB(P_WB)) u_rob_top (
      .clk(clk), .arst_n(arst_n), .flush(flush),
      .rob_push_size(push_size), .rob_push_pc(push_pc), .rob_push_lrd(push_lrd),
      .rob_push_prd(push_prd), .rob_push_prd_we(push_we), .rob_ready(rob_ready),
      .rob_free_id(free_id), .rob_free_bank(free_bank),
      .wb_valid(wb_valid), .wb_rob_id(wb_id), .wb_rob_bank(wb_bank), .wb_exc(wb_exc),
      .wb_data(wb_data), .wb_rob_ready(wb_ready),
      .cmt_valid(cmt_valid), .cmt_pc(cmt_pc), .cmt_lrd(cmt_lrd), .cmt_prd(cmt_prd),
      .cmt_prd_we(cmt_we), .cmt_exc(cmt_exc), .cmt_data(cmt_data),
      .cmt_pop_size(pop_size)
   );

   bind rob_top rob_props #(.P_BANKS(P_BANKS), .P_WB(P_WB)) u_props (
      .clk(clk), .arst_n(arst_n), .flush(flush),
      .cmt_valid(cmt_valid), .wb_rob_ready(wb_rob_ready)
   );

   always #10 clk = ~clk;

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles > limit)
      begin
         $display("timeout: run did not finish within %0d cycles", limit);
         $display("sim failed");
         $finish;
      end
   end

   // Result value written back for an entry
   function automatic logic [31:0] result_of(input logic [31:0] pc);
      return {pc[15:0], ~pc[15:0]};
   endfunction

   function automatic bit model_ready();
      for (int b = 0; b < NB; b++)
         if (push_cnt[b] - pop_cnt[b] >= ND)
            return 1'b0;
      return 1'b1;
   endfunction

   function automatic logic [NB-1:0] done_prefix();
      logic [NB-1:0] m;
      m = '0;
      for (int i = 0; i < NB && i < q_pc.size(); i++)
      begin
         if (!q_done[i])
            break;
         m[i] = 1'b1;
      end
      return m;
   endfunction

   task automatic expect_val(input logic [63:0] got, input logic [63:0] exp, input string msg);
      assert (got === exp)
      else
      begin
         $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
         errors++;
      end
   endtask

   task automatic free_slots();
      for (int i = 0; i < NB; i++)
      begin
         expect_val(64'(free_bank[i]), 64'((tail_cnt + i) % NB), "free bank");
         expect_val(64'(free_id[i]), 64'(push_cnt[(tail_cnt + i) % NB] % ND), "free id");
      end
   endtask

   task automatic push_row(input int n, input logic [31:0] pc, input int lrd, input int prd);
      int b;
      expect_val(64'(rob_ready), 64'(model_ready()), "rob_ready before push");
      free_slots();
      for (int i = 0; i < n; i++)
      begin
         b = (tail_cnt + i) % NB;
         push_pc[i]  = pc + 32'(4 * i);
         push_lrd[i] = 5'(lrd + i);
         push_prd[i] = 6'(prd + i);
         push_we[i]  = (i % 2 == 0);
         q_pc.push_back(push_pc[i]);
         q_lrd.push_back(push_lrd[i]);
         q_prd.push_back(push_prd[i]);
         q_we.push_back(push_we[i]);
         q_done.push_back(1'b0);
         q_bank.push_back(b);
         q_id.push_back(push_cnt[b] % ND);
         push_cnt[b]++;
      end
      tail_cnt = (tail_cnt + n) % NB;
      push_size = (P_BANKS+1)'(n);
      @(posedge clk);
      #2 push_size = '0;
   endtask

   // Ports carry model entries q0 and q1, a negative index leaves a port idle
   task automatic write_back(input int q0, input int q1, input bit rdy1);
      int q[2];
      q[0] = q0;
      q[1] = q1;
      for (int p = 0; p < 2; p++)
         if (q[p] >= 0)
         begin
            wb_valid[p] = 1'b1;
            wb_bank[p]  = P_BANKS'(q_bank[q[p]]);
            wb_id[p]    = P_DEPTH'(q_id[q[p]]);
            wb_exc[p]   = q_pc[q[p]][3];
            wb_data[p]  = result_of(q_pc[q[p]]);
         end
      #1;
      if (q0 >= 0)
         expect_val(64'(wb_ready[0]), 64'(1), "writeback port 0 ready");
      if (q1 >= 0)
         expect_val(64'(wb_ready[1]), 64'(rdy1), "writeback port 1 ready");
      @(posedge clk);
      #2 wb_valid = '0;
      if (q0 >= 0)
         q_done[q0] = 1'b1;
      if (q1 >= 0 && rdy1)
         q_done[q1] = 1'b1;
   endtask

   task automatic shuffled_writebacks(input logic [3:0] mask);
      int idx[$];
      int k;
      int t;
      for (int i = 0; i < 4; i++)
         if (mask[i] && i < q_pc.size())
            idx.push_back(i);
      for (int i = idx.size() - 1; i > 0; i--)
      begin
         k = int'($urandom % (i + 1));
         t = idx[i];
         idx[i] = idx[k];
         idx[k] = t;
      end
      foreach (idx[i])
      begin
         write_back(idx[i], -1, 1'b0);
         expect_val(64'(cmt_valid), 64'(done_prefix()), "cmt_valid after writeback");
      end
   endtask

   task automatic commit_lanes(input int n);
      logic [NB-1:0] m;
      m = done_prefix();
      expect_val(64'(cmt_valid), 64'(m), "cmt_valid prefix");
      expect_val(64'($countones(m) >= n), 64'(1), "commit count available");
      for (int i = 0; i < n && i < q_pc.size(); i++)
      begin
         expect_val(64'(cmt_pc[i]), 64'(q_pc[i]), "cmt_pc");
         expect_val(64'(cmt_lrd[i]), 64'(q_lrd[i]), "cmt_lrd");
         expect_val(64'(cmt_prd[i]), 64'(q_prd[i]), "cmt_prd");
         expect_val(64'(cmt_we[i]), 64'(q_we[i]), "cmt_prd_we");
         expect_val(64'(cmt_exc[i]), 64'(q_pc[i][3]), "cmt_exc");
         expect_val(64'(cmt_data[i]), 64'(result_of(q_pc[i])), "cmt_data");
      end
      pop_size = (P_BANKS+1)'(n);
      @(posedge clk);
      #2 pop_size = '0;
      for (int i = 0; i < n && q_pc.size() > 0; i++)
      begin
         pop_cnt[q_bank[0]]++;
         void'(q_pc.pop_front());
         void'(q_lrd.pop_front());
         void'(q_prd.pop_front());
         void'(q_we.pop_front());
         void'(q_done.pop_front());
         void'(q_bank.pop_front());
         void'(q_id.pop_front());
      end
   endtask

   task automatic flush_all();
      flush = 1'b1;
      @(posedge clk);
      #2 flush = 1'b0;
      q_pc.delete();
      q_lrd.delete();
      q_prd.delete();
      q_we.delete();
      q_done.delete();
      q_bank.delete();
      q_id.delete();
      for (int b = 0; b < NB; b++)
      begin
         push_cnt[b] = 0;
         pop_cnt[b]  = 0;
      end
      tail_cnt = 0;
   endtask

   initial
   begin
      int fd;
      int nlines;
      int a;
      int b;
      int d;
      int test_err;
      int tests_ok;
      int tests_bad;
      string line;
      string c;
      logic [31:0] h;
      clk = 0;
      arst_n = 0;
      flush = 0;
      push_size = '0;
      push_pc = '0;
      push_lrd = '0;
      push_prd = '0;
      push_we = '0;
      wb_valid = '0;
      wb_id = '0;
      wb_bank = '0;
      wb_exc = '0;
      wb_data = '0;
      pop_size = '0;
      errors = 0;
      cycles = 0;
      limit = 0;
      tail_cnt = 0;
      nlines = 0;
      test_err = 0;
      tests_ok = 0;
      tests_bad = 0;
      void'($urandom(219));
      for (int i = 0; i < NB; i++)
      begin
         push_cnt[i] = 0;
         pop_cnt[i]  = 0;
      end
      fd = $fopen("bench/rob_patterns.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the pattern file");
         $display("sim failed");
         $finish;
      end
      else
      begin
         while ($fgets(line, fd))
            nlines++;
         $fclose(fd);
         limit = 4 * nlines + 16 + 50;
         fd = $fopen("bench/rob_patterns.txt", "r");
         repeat (16) @(posedge clk);
         #2 arst_n = 1'b1;
         while ($fgets(line, fd))
         begin
            if (line.len() < 2 || line.getc(0) == "#")
               continue;
            case (line.getc(0))
               "P":
               begin
                  void'($sscanf(line, "%s %d %h %d %d", c, a, h, b, d));
                  push_row(a, h, b, d);
               end
               "W":
               begin
                  void'($sscanf(line, "%s %d %d %d", c, a, b, d));
                  write_back(a, b, d[0]);
               end
               "X":
               begin
                  void'($sscanf(line, "%s %h", c, h));
                  shuffled_writebacks(h[3:0]);
               end
               "C":
               begin
                  void'($sscanf(line, "%s %d", c, a));
                  commit_lanes(a);
               end
               "F": flush_all();
               "R":
               begin
                  expect_val(64'(cmt_valid), 64'(0), "idle cmt_valid");
                  expect_val(64'(rob_ready), 64'(1), "idle rob_ready");
                  free_slots();
               end
               "Y":
               begin
                  void'($sscanf(line, "%s %d", c, a));
                  expect_val(64'(rob_ready), 64'(a), "rob_ready");
                  expect_val(64'(model_ready()), 64'(a), "model ready");
               end
               "E":
               begin
                  void'($sscanf(line, "%s %d", c, a));
                  if (errors == test_err)
                  begin
                     $display("test %0d passed", a);
                     tests_ok++;
                  end
                  else
                  begin
                     $display("test %0d failed with %0d errors", a, errors - test_err);
                     tests_bad++;
                  end
                  test_err = errors;
               end
               default:
               begin
                  $display("unknown command in pattern file: %s", line);
                  errors++;
               end
            endcase
         end
         $fclose(fd);
         $display("tests passed: %0d, failed: %0d", tests_ok, tests_bad);
         if (errors == 0 && tests_bad == 0)
            $display("sim passed");
         else
            $display("sim failed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: bench/rob_patterns.txt
# P count pc lrd prd | W q0 q1 ready1 | X mask | C count | F | R | Y ready | E test
# q0, q1 and mask bits index model entries from the oldest, -1 leaves a port idle
R
E 1
P 4 100 1 10
X 6
X 1
C 3
X 1
C 1
R
E 2
P 4 200 5 20
P 1 300 9 30
W 0 4 0
C 0
X e
W -1 4 1
C 4
C 1
E 3
F
P 4 400 1 1
P 4 410 2 2
P 4 420 3 3
P 4 430 4 4
P 4 440 5 5
P 4 450 6 6
P 4 460 7 7
P 4 470 8 8
Y 0
X f
C 4
Y 1
E 4
X f
C 2
X c
C 3
X e
C 1
P 4 500 9 40
C 3
X f
C 4
X f
C 2
E 5
F
R
E 6

// File: vlog.f
design/rob_cfg_pkg.sv
design/rob_entry_pkg.sv
design/rob_bank.sv
design/rob_wb_router.sv
design/rob_top.sv
bench/rob_props.sv
bench/tb_rob.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = tb_rob
FLIST = vlog.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
